//--- verilog/mpu_defs.svh
`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

// Task maps held in the descriptor bank
`define MPU_MAPS 9

// Descriptors per task map
`define MPU_ROWS 4

// Stored interrupt levels, higher priorities share the last one
`define MPU_LEVELS 4

// Lowest legal stack address
`define MPU_STACK_FLOOR 1280

// CSR address of descriptor 0
// Row r of map k sits at MPU_CSR_BASE + k * MPU_ROWS + r
`define MPU_CSR_BASE 12'h500

// Total descriptors in the bank
`define MPU_ENTRIES (`MPU_MAPS * `MPU_ROWS)

`endif

//--- verilog/csr_pkg.sv
package csr_pkg;

    // 12-bit CSR address space
    typedef logic [11:0] csr_addr_t;

    // Write style, same meaning as csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0, // Replace
        CSR_SET   = 2'd1, // OR data in
        CSR_CLEAR = 2'd2  // Remove data bits
    } csr_op_t;

    // One write command, 46 bits
    typedef struct packed {
        csr_addr_t   addr;
        csr_op_t     op;
        logic [31:0] data;
    } csr_cmd_t;

endpackage

//--- verilog/mpu_pkg.sv
package mpu_pkg;

    // Region descriptor, layout matches the 32-bit CSR word
    typedef struct packed {
        logic [15:0] base;     // Lowest address of the region
        logic [13:0] length;   // End is base + length, inclusive
        logic        write_en;
        logic        read_en;
    } region_t;

    // RISC-V major opcodes that touch memory
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_t;

    // Decoded access kind
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0, // Not a memory access
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_kind_t;

    // Access presented to both checkers, 18 bits
    typedef struct packed {
        logic [15:0]  addr;
        access_kind_t kind;
    } access_t;

endpackage

//--- verilog/mpu_region_table.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_region_table
    import csr_pkg::*, mpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       csr_enable,
    input  csr_cmd_t   csr_cmd,
    input  logic [3:0] id,
    output region_t    current_map [`MPU_ROWS]
);

    region_t   table_q [`MPU_ENTRIES];
    region_t   table_d [`MPU_ENTRIES];  // Bank including this cycle's write
    region_t   map_d [`MPU_ROWS];
    csr_addr_t offset;
    logic      hit;

    // Apply one CSR operation to a descriptor
    function automatic region_t apply_op(region_t cur, csr_cmd_t cmd);
        logic [31:0] bits;
        bits = cur;
        case (cmd.op)
            CSR_WRITE: bits = cmd.data;
            CSR_SET:   bits = bits | cmd.data;
            CSR_CLEAR: bits = bits & ~cmd.data;
            default:   bits = cur;
        endcase
        return region_t'(bits);
    endfunction

    // Address decode against the descriptor window
    assign offset = csr_cmd.addr - `MPU_CSR_BASE;
    assign hit = csr_enable && (csr_cmd.addr >= `MPU_CSR_BASE)
                 && (csr_cmd.addr < `MPU_CSR_BASE + `MPU_ENTRIES);

    always_comb begin
        table_d = table_q;
        for (int i = 0; i < `MPU_ENTRIES; i++) begin
            if (hit && offset == csr_addr_t'(i)) begin
                table_d[i] = apply_op(table_q[i], csr_cmd);
            end
        end
    end

    // Rows of the selected task, unknown ids get an empty map
    always_comb begin
        for (int r = 0; r < `MPU_ROWS; r++) begin
            if (id < `MPU_MAPS) begin
                map_d[r] = table_d[id * `MPU_ROWS + r];
            end else begin
                map_d[r] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            table_q     <= '{default: '0};
            current_map <= '{default: '0}; // Nothing granted after reset
        end else begin
            table_q     <= table_d;
            current_map <= map_d;
        end
    end

endmodule

//--- verilog/mpu_region_check.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_region_check
    import mpu_pkg::*;
(
    input  access_t access,
    input  region_t current_map [`MPU_ROWS],
    output logic    region_grant
);

    logic [16:0]          row_end [`MPU_ROWS]; // Extra bit keeps the end from wrapping
    logic [`MPU_ROWS-1:0] in_range;
    logic [`MPU_ROWS-1:0] row_grant;

    always_comb begin
        for (int r = 0; r < `MPU_ROWS; r++) begin
            row_end[r]  = {1'b0, current_map[r].base} + {3'b000, current_map[r].length};
            in_range[r] = (access.addr >= current_map[r].base)
                          && ({1'b0, access.addr} <= row_end[r]);

            // Permission bit depends on the direction
            case (access.kind)
                ACC_LOAD:  row_grant[r] = in_range[r] && current_map[r].read_en;
                ACC_STORE: row_grant[r] = in_range[r] && current_map[r].write_en;
                default:   row_grant[r] = 1'b0;
            endcase
        end
    end

    // Any matching row is enough
    assign region_grant = |row_grant;

endmodule

//--- verilog/mpu_stack_window.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_stack_window
    import mpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  access_t     access,
    input  logic [15:0] sp,
    input  logic [7:0]  interrupt_prio,
    output logic        stack_outside
);

    localparam int LVL_W = $clog2(`MPU_LEVELS);
    localparam logic [LVL_W-1:0] LAST_LVL = LVL_W'(`MPU_LEVELS - 1);

    logic [LVL_W-1:0] level;
    logic [LVL_W-1:0] level_q;                 // Level seen at the previous edge
    logic [15:0]      entry_sp [`MPU_LEVELS];  // Stack pointer at level entry
    logic [15:0]      entry_ptr;

    // Clamp priority onto the stored levels
    always_comb begin
        if (interrupt_prio > 8'(`MPU_LEVELS - 1)) begin
            level = LAST_LVL;
        end else begin
            level = interrupt_prio[LVL_W-1:0];
        end
    end

    // Capture sp on every level change
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_sp <= '{default: '0};
            level_q  <= '0;
        end else begin
            if (level != level_q) begin
                entry_sp[level] <= sp;
            end
            level_q <= level;
        end
    end

    assign entry_ptr = entry_sp[level]; // Stored value, not this cycle's sp

    // Window is floor up to the entry pointer, both ends inclusive
    assign stack_outside = (access.addr > entry_ptr)
                           || (access.addr < 16'(`MPU_STACK_FLOOR));

endmodule

//--- verilog/mpu.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu
    import csr_pkg::*, mpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        csr_enable,
    input  csr_cmd_t    csr_cmd,
    input  logic [15:0] mem_address,
    input  logic [6:0]  op,
    input  logic [15:0] sp,
    input  logic [7:0]  interrupt_prio,
    input  logic [3:0]  id,
    output logic        mem_fault,
    output logic        mem_fault_ff
);

    access_t access;
    region_t current_map [`MPU_ROWS];
    logic    region_grant;
    logic    stack_outside;

    // Opcode decode, shared by both checkers
    always_comb begin
        access.addr = mem_address;
        case (op)
            OP_LOAD:  access.kind = ACC_LOAD;
            OP_STORE: access.kind = ACC_STORE;
            default:  access.kind = ACC_NONE;
        endcase
    end

    mpu_region_table region_table_inst (
        .clk         (clk),
        .reset       (reset),
        .csr_enable  (csr_enable),
        .csr_cmd     (csr_cmd),
        .id          (id),
        .current_map (current_map)
    );

    mpu_region_check region_check_inst (
        .access       (access),
        .current_map  (current_map),
        .region_grant (region_grant)
    );

    mpu_stack_window stack_window_inst (
        .clk            (clk),
        .reset          (reset),
        .access         (access),
        .sp             (sp),
        .interrupt_prio (interrupt_prio),
        .stack_outside  (stack_outside)
    );

    // Fault only when both checks reject
    assign mem_fault = (access.kind != ACC_NONE) && !region_grant && stack_outside;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_fault_ff <= 1'b0;
        end else begin
            mem_fault_ff <= mem_fault; // Registered copy for the interrupt controller
        end
    end

endmodule

//--- sim/mpu_properties.sv
`timescale 1ns/1ps

module mpu_properties
    import mpu_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic [6:0] op,
    input logic       mem_fault,
    input logic       mem_fault_ff
);

    // Registered fault trails the live one by a cycle
    fault_delay: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> mem_fault_ff == $past(mem_fault))
        else $error("mem_fault_ff does not follow mem_fault");

    fault_needs_access: assert property (@(posedge clk) disable iff (reset)
        mem_fault |-> (op == OP_LOAD || op == OP_STORE))
        else $error("fault raised for an opcode that is neither load nor store");

    // First cycle out of reset
    clear_after_reset: assert property (@(posedge clk) $fell(reset) |-> !mem_fault_ff)
        else $error("mem_fault_ff high right after reset");

endmodule

bind mpu mpu_properties properties_inst (
    .clk          (clk),
    .reset        (reset),
    .op           (op),
    .mem_fault    (mem_fault),
    .mem_fault_ff (mem_fault_ff)
);

//--- sim/mpu_tb.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_tb
    import csr_pkg::*, mpu_pkg::*;
();

    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 100;  // Upper bound for the directed phases
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_NS      = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 10 * 2;
    localparam logic [6:0] OP_IMM  = 7'b0010011;  // ALU opcode that never touches memory

    logic        clk;
    logic        reset;
    logic        csr_enable;
    csr_cmd_t    csr_cmd;
    logic [15:0] mem_address;
    logic [6:0]  op;
    logic [15:0] sp;
    logic [7:0]  interrupt_prio;
    logic [3:0]  id;
    logic        mem_fault;
    logic        mem_fault_ff;

    // Reference copies of the DUT state
    logic [31:0] ref_table [`MPU_ENTRIES];
    region_t     ref_map [`MPU_ROWS];        // Selected map one cycle late
    logic [15:0] ref_entry_sp [`MPU_LEVELS];
    int          prev_level;
    logic        exp_fault;
    logic        prev_fault;
    logic [31:0] rng = 32'd33090;
    int          error_count = 0;

    mpu mpu_inst (
        .clk            (clk),
        .reset          (reset),
        .csr_enable     (csr_enable),
        .csr_cmd        (csr_cmd),
        .mem_address    (mem_address),
        .op             (op),
        .sp             (sp),
        .interrupt_prio (interrupt_prio),
        .id             (id),
        .mem_fault      (mem_fault),
        .mem_fault_ff   (mem_fault_ff)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int level_of(logic [7:0] prio);
        if (prio > 8'(`MPU_LEVELS - 1)) begin
            return `MPU_LEVELS - 1;  // Higher priorities share the last level
        end
        return int'(prio);
    endfunction

    function automatic csr_addr_t row_addr(int map, int row);
        return csr_addr_t'(`MPU_CSR_BASE + map * `MPU_ROWS + row);
    endfunction

    // CSR word holds base, length, write enable and read enable
    function automatic logic [31:0] region_word(logic [15:0] base, logic [13:0] length,
                                                logic we, logic re);
        return {base, length, we, re};
    endfunction

    // Fault when neither a region nor the stack window accepts a load or store
    function automatic logic expected_fault(logic [6:0] opcode, logic [15:0] addr,
                                            logic [15:0] ptr);
        logic        grant;
        logic        outside;
        logic [16:0] last;
        if (opcode != OP_LOAD && opcode != OP_STORE) begin
            return 1'b0;
        end
        grant = 1'b0;
        for (int r = 0; r < `MPU_ROWS; r++) begin
            last = 17'(ref_map[r].base) + 17'(ref_map[r].length);  // No wrap past the top
            if (addr >= ref_map[r].base && {1'b0, addr} <= last) begin
                if (opcode == OP_LOAD && ref_map[r].read_en) grant = 1'b1;
                if (opcode == OP_STORE && ref_map[r].write_en) grant = 1'b1;
            end
        end
        outside = (addr > ptr) || (addr < 16'(`MPU_STACK_FLOOR));
        return !grant && outside;
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            error_count++;
            $display("error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Advance the model over the coming edge with the inputs now applied
    task automatic update_model();
        int idx;
        int lvl;
        if (reset) begin
            ref_table    = '{default: '0};
            ref_map      = '{default: '0};
            ref_entry_sp = '{default: '0};
            prev_level   = 0;
            prev_fault   = 1'b0;
        end else begin
            if (csr_enable && csr_cmd.addr >= `MPU_CSR_BASE
                && csr_cmd.addr < `MPU_CSR_BASE + `MPU_ENTRIES) begin
                idx = int'(csr_cmd.addr - `MPU_CSR_BASE);
                case (csr_cmd.op)
                    CSR_WRITE: ref_table[idx] = csr_cmd.data;
                    CSR_SET:   ref_table[idx] = ref_table[idx] | csr_cmd.data;
                    CSR_CLEAR: ref_table[idx] = ref_table[idx] & ~csr_cmd.data;
                    default:   ref_table[idx] = ref_table[idx];
                endcase
            end
            for (int r = 0; r < `MPU_ROWS; r++) begin
                ref_map[r] = (id < `MPU_MAPS) ? region_t'(ref_table[id * `MPU_ROWS + r]) : '0;
            end
            lvl = level_of(interrupt_prio);
            if (lvl != prev_level) ref_entry_sp[lvl] = sp;  // Capture on level change
            prev_level = lvl;
            prev_fault = exp_fault;
        end
    endtask

    // Compare just before each rising edge
    initial begin
        forever begin
            @(posedge clk);
            #8;
            if (!reset) begin
                exp_fault = expected_fault(op, mem_address,
                                           ref_entry_sp[level_of(interrupt_prio)]);
                compare_value("mem_fault", 32'(mem_fault), 32'(exp_fault));
                compare_value("mem_fault_ff", 32'(mem_fault_ff), 32'(prev_fault));
            end
            update_model();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(int cycles);
        op = OP_IMM;
        repeat (cycles) next_cycle();
    endtask

    task automatic csr_access(csr_addr_t addr, csr_op_t cmd_op, logic [31:0] data);
        op           = OP_IMM;
        csr_enable   = 1'b1;
        csr_cmd.addr = addr;
        csr_cmd.op   = cmd_op;
        csr_cmd.data = data;
        next_cycle();
        csr_enable = 1'b0;
    endtask

    // Apply one access and also check it against a fixed expectation
    task automatic access_expect(logic [6:0] opcode, logic [15:0] addr, logic want);
        op          = opcode;
        mem_address = addr;
        #3;
        compare_value("mem_fault", 32'(mem_fault), 32'(want));
        next_cycle();
    endtask

    task automatic set_stack(logic [7:0] prio, logic [15:0] ptr);
        interrupt_prio = prio;
        sp             = ptr;
        idle(1);
        sp = 16'hFFFF;  // Differs from any stored pointer
    endtask

    task automatic random_cycle();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        rng = xorshift(rng);
        a   = rng;
        rng = xorshift(rng);
        b   = rng;
        rng = xorshift(rng);
        c   = rng;
        rng = xorshift(rng);
        d   = rng;
        csr_enable   = (a[2:0] == 3'd0);
        csr_cmd.addr = csr_addr_t'(`MPU_CSR_BASE - 2 + a[9:3] % 40);  // Some miss the table
        csr_cmd.op   = csr_op_t'(2'(a[31:24] % 3));
        csr_cmd.data = a[10] ? c : (c & 32'h1FFF_FFFF);  // Mostly low bases
        if (a[13:11] == 3'd0) id = b[3:0];
        if (a[16:14] == 3'd0) interrupt_prio = b[8] ? 8'(b[5:4]) : b[15:8];
        sp = b[31:16] & 16'h1FFF;
        case (b[7:6])
            2'd0:    op = OP_LOAD;
            2'd1:    op = OP_STORE;
            2'd2:    op = OP_LOAD;
            default: op = a[23:17];
        endcase
        mem_address = d[16] ? d[15:0] : (d[15:0] & 16'h1FFF);
        next_cycle();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset          = 1'b1;
        csr_enable     = 1'b0;
        csr_cmd        = '0;
        mem_address    = '0;
        op             = OP_IMM;
        sp             = '0;
        interrupt_prio = '0;
        id             = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        // Empty table and zero entry pointers
        access_expect(OP_LOAD, 16'h0100, 1'b1);
        access_expect(OP_STORE, 16'h1000, 1'b1);
        access_expect(OP_IMM, 16'h0100, 1'b0);

        // Toggle read enable of one descriptor
        csr_access(row_addr(0, 0), CSR_WRITE, region_word(16'h2000, 14'h0100, 1'b0, 1'b0));
        access_expect(OP_LOAD, 16'h2080, 1'b1);
        csr_access(row_addr(0, 0), CSR_SET, 32'h1);
        access_expect(OP_LOAD, 16'h2080, 1'b0);
        csr_access(row_addr(0, 0), CSR_CLEAR, 32'h1);
        access_expect(OP_LOAD, 16'h2080, 1'b1);
        csr_access(12'h4FF, CSR_WRITE, region_word(16'h2000, 14'h0100, 1'b1, 1'b1));
        csr_access(row_addr(`MPU_MAPS, 0), CSR_WRITE,
                   region_word(16'h2000, 14'h0100, 1'b1, 1'b1));
        access_expect(OP_LOAD, 16'h2080, 1'b1);

        // Read-only region edges and a region near the top of memory
        csr_access(row_addr(0, 1), CSR_WRITE, region_word(16'h3000, 14'h0040, 1'b0, 1'b1));
        access_expect(OP_LOAD, 16'h3000, 1'b0);
        access_expect(OP_LOAD, 16'h3040, 1'b0);
        access_expect(OP_LOAD, 16'h3041, 1'b1);
        access_expect(OP_STORE, 16'h3010, 1'b1);
        access_expect(7'b0110011, 16'h3041, 1'b0);
        access_expect(7'b1100011, 16'h3041, 1'b0);
        csr_access(row_addr(0, 2), CSR_WRITE, region_word(16'hFFF0, 14'h3FFF, 1'b1, 1'b1));
        access_expect(OP_LOAD, 16'hFFFF, 1'b0);
        access_expect(OP_LOAD, 16'h0005, 1'b1);

        // Stack window per interrupt level
        set_stack(8'd1, 16'h0800);
        access_expect(OP_LOAD, 16'h0700, 1'b0);
        access_expect(OP_STORE, 16'h0800, 1'b0);
        access_expect(OP_LOAD, 16'h0801, 1'b1);
        access_expect(OP_LOAD, 16'h0400, 1'b1);
        set_stack(8'd7, 16'h0A00);
        access_expect(OP_LOAD, 16'h09FF, 1'b0);
        set_stack(8'd200, 16'h0B00);  // Same level keeps its pointer
        access_expect(OP_LOAD, 16'h0A80, 1'b1);
        set_stack(8'd1, 16'h0C00);
        access_expect(OP_LOAD, 16'h0B00, 1'b0);
        set_stack(8'd0, 16'h0600);
        access_expect(OP_LOAD, 16'h0600, 1'b0);
        access_expect(OP_LOAD, 16'h0700, 1'b1);

        // Task switch takes one cycle
        csr_access(row_addr(5, 0), CSR_WRITE, region_word(16'h4000, 14'h0010, 1'b1, 1'b1));
        access_expect(OP_STORE, 16'h4008, 1'b1);
        id = 4'd5;
        access_expect(OP_STORE, 16'h4008, 1'b1);
        access_expect(OP_STORE, 16'h4008, 1'b0);
        id = 4'd12;
        access_expect(OP_STORE, 16'h4008, 1'b0);
        access_expect(OP_STORE, 16'h4008, 1'b1);
        id = 4'd0;
        idle(1);

        repeat (RANDOM_CYCLES) random_cycle();
        csr_enable = 1'b0;
        idle(3);

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/mpu_pkg.sv
verilog/mpu_region_table.sv
verilog/mpu_region_check.sv
verilog/mpu_stack_window.sv
verilog/mpu.sv
sim/mpu_properties.sv
sim/mpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mpu_tb -f all.f -o mpu_sim
./obj_dir/mpu_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
